// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbOooCore
FILELIST = vlog.f
OBJDIR   = obj_dir
LOG      = sim.log
PASSMSG  = ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASSMSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: logic/aluPipe.sv
// two-stage ALU pipeline driving the common data bus
`timescale 1ns/10ps
`default_nettype none

module aluPipe import oooPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  issueReq issue,
  output cdbMsg   cdb
);

  // first stage request
  issueReq s1;
  word result;

  always_comb begin
    case (s1.op)
      opAdd:   result = s1.srcA + s1.srcB;
      opSub:   result = s1.srcA - s1.srcB;
      opAnd:   result = s1.srcA & s1.srcB;
      opOr:    result = s1.srcA | s1.srcB;
      opXor:   result = s1.srcA ^ s1.srcB;
      // shift amount from low five bits
      opSll:   result = s1.srcA << s1.srcB[4:0];
      opSrl:   result = s1.srcA >> s1.srcB[4:0];
      opSlt:   result = {31'b0, $signed(s1.srcA) < $signed(s1.srcB)};
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      s1 <= '0;
      cdb <= '0;
    end else begin
      s1 <= issue;
      // second stage puts the result on the bus
      cdb.valid <= s1.valid;
      cdb.tag <= s1.tag;
      cdb.value <= result;
    end
  end

endmodule

`default_nettype wire

// File: logic/aluStation.sv
// ALU reservation station with operand capture, bus wakeup and oldest-ready select
`timescale 1ns/10ps
`default_nettype none

module aluStation import oooPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  logic    dispatchFire,
  input  aluOp    op,
  input  operand  srcA,
  input  operand  srcB,
  input  robTag   allocTag,
  input  cdbMsg   cdb,
  output logic    stationFull,
  output issueReq issue
);

  localparam int slotBits = $clog2(stationDepth);

  logic [stationDepth-1:0] slotValid;
  aluOp slotOp [stationDepth];
  operand slotA [stationDepth];
  operand slotB [stationDepth];
  robTag slotTag [stationDepth];
  // bit j set when slot j was accepted before this slot
  logic [stationDepth-1:0] older [stationDepth];

  // both operands present
  logic [stationDepth-1:0] slotReady;
  logic [slotBits-1:0] freeSlot;
  logic [slotBits-1:0] issueSlot;
  logic issueHit;

  // capture a broadcast value into a waiting operand
  function automatic operand wake(operand o, cdbMsg c);
    operand r;
    r = o;
    if (!o.ready && c.valid && c.tag == o.tag) begin
      r.ready = 1'b1;
      r.value = c.value;
    end
    return r;
  endfunction

  assign stationFull = &slotValid;

  always_comb begin
    for (int i = 0; i < stationDepth; i++) begin
      slotReady[i] = slotValid[i] && slotA[i].ready && slotB[i].ready;
    end
  end

  // lowest free slot
  always_comb begin
    freeSlot = '0;
    for (int i = stationDepth - 1; i >= 0; i--) begin
      if (!slotValid[i]) freeSlot = slotBits'(i);
    end
  end

  // ready slot with no older ready slot
  always_comb begin
    issueHit = 1'b0;
    issueSlot = '0;
    for (int i = 0; i < stationDepth; i++) begin
      if (slotReady[i] && (slotReady & older[i]) == '0) begin
        issueHit = 1'b1;
        issueSlot = slotBits'(i);
      end
    end
  end

  always_comb begin
    issue.valid = issueHit;
    issue.op = slotOp[issueSlot];
    issue.srcA = slotA[issueSlot].value;
    issue.srcB = slotB[issueSlot].value;
    issue.tag = slotTag[issueSlot];
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      slotValid <= '0;
    end else begin
      if (issueHit) slotValid[issueSlot] <= 1'b0;
      if (dispatchFire) slotValid[freeSlot] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    // wakeup of waiting operands
    for (int i = 0; i < stationDepth; i++) begin
      slotA[i] <= wake(slotA[i], cdb);
      slotB[i] <= wake(slotB[i], cdb);
    end
    if (dispatchFire) begin
      // newcomer is younger than everything present
      for (int i = 0; i < stationDepth; i++) begin
        older[i][freeSlot] <= 1'b0;
      end
      older[freeSlot] <= slotValid;
      slotOp[freeSlot] <= op;
      slotTag[freeSlot] <= allocTag;
      // same-cycle broadcast caught on the way in
      slotA[freeSlot] <= wake(srcA, cdb);
      slotB[freeSlot] <= wake(srcB, cdb);
    end
  end

endmodule

`default_nettype wire

// File: logic/oooCore.sv
// back end top level with dispatch port, rename, ROB, ALU station, ALU pipe and commit port
`timescale 1ns/10ps
`default_nettype none

module oooCore import oooPkg::*; (
  input  logic       clk,
  input  logic       arstN,
  input  logic       dispatchValid,
  input  dispatchReq dispatch,
  output logic       dispatchReady,
  output commitMsg   commit
);

  logic dispatchFire;
  logic robFull;
  logic stationFull;
  robTag allocTag;
  robTag queryTagA;
  robTag queryTagB;
  robTag commitTag;
  operand queryA;
  operand queryB;
  operand srcA;
  operand srcB;
  cdbMsg cdb;
  issueReq issue;

  // ready from state only
  assign dispatchReady = !robFull && !stationFull;
  assign dispatchFire = dispatchValid && dispatchReady;

  renameTable rename (
    .clk          (clk),
    .arstN        (arstN),
    .dispatchFire (dispatchFire),
    .dispatch     (dispatch),
    .allocTag     (allocTag),
    .queryTagA    (queryTagA),
    .queryTagB    (queryTagB),
    .queryA       (queryA),
    .queryB       (queryB),
    .srcA         (srcA),
    .srcB         (srcB),
    .commit       (commit),
    .commitTag    (commitTag)
  );

  reorderBuffer rob (
    .clk          (clk),
    .arstN        (arstN),
    .dispatchFire (dispatchFire),
    .rd           (dispatch.rd),
    .allocTag     (allocTag),
    .robFull      (robFull),
    .queryTagA    (queryTagA),
    .queryTagB    (queryTagB),
    .queryA       (queryA),
    .queryB       (queryB),
    .cdb          (cdb),
    .commit       (commit),
    .commitTag    (commitTag)
  );

  aluStation station (
    .clk          (clk),
    .arstN        (arstN),
    .dispatchFire (dispatchFire),
    .op           (dispatch.op),
    .srcA         (srcA),
    .srcB         (srcB),
    .allocTag     (allocTag),
    .cdb          (cdb),
    .stationFull  (stationFull),
    .issue        (issue)
  );

  aluPipe pipe (
    .clk   (clk),
    .arstN (arstN),
    .issue (issue),
    .cdb   (cdb)
  );

endmodule

`default_nettype wire

// File: logic/oooPkg.sv
// widths, sizes, ALU operation enum and the structs passed between back end blocks
`default_nettype none

package oooPkg;

  // data value
  typedef logic [31:0] word;
  // architectural register number, register 0 reads as zero
  typedef logic [3:0] regIdx;
  // reorder buffer entry number, doubles as the rename tag
  typedef logic [2:0] robTag;

  // sizes
  localparam int robDepth = 8;
  localparam int stationDepth = 4;
  localparam int regCount = 16;

  // ALU operations
  typedef enum logic [2:0] {
    opAdd,
    opSub,
    opAnd,
    opOr,
    opXor,
    opSll,
    opSrl,
    opSlt
  } aluOp;

  // instruction as it arrives at dispatch
  typedef struct packed {
    aluOp op;
    regIdx rd;
    regIdx rs1;
    regIdx rs2;
    logic useImm;
    word imm;
  } dispatchReq;

  // captured value, or the tag that will produce it
  typedef struct packed {
    logic ready;
    robTag tag;
    word value;
  } operand;

  // one broadcast on the common data bus
  typedef struct packed {
    logic valid;
    robTag tag;
    word value;
  } cdbMsg;

  // one retired instruction
  typedef struct packed {
    logic valid;
    regIdx rd;
    word value;
  } commitMsg;

  // station to ALU
  typedef struct packed {
    logic valid;
    aluOp op;
    word srcA;
    word srcB;
    robTag tag;
  } issueReq;

endpackage

`default_nettype wire

// File: logic/renameTable.sv
// architectural register file and register status table with dispatch operand lookup
`timescale 1ns/10ps
`default_nettype none

module renameTable import oooPkg::*; (
  input  logic       clk,
  input  logic       arstN,
  input  logic       dispatchFire,
  input  dispatchReq dispatch,
  input  robTag      allocTag,
  output robTag      queryTagA,
  output robTag      queryTagB,
  input  operand     queryA,
  input  operand     queryB,
  output operand     srcA,
  output operand     srcB,
  input  commitMsg   commit,
  input  robTag      commitTag
);

  // committed register values
  word regFile [regCount];
  // register waits on an in-flight result
  logic [regCount-1:0] busy;
  // youngest producer of each busy register
  robTag tagOf [regCount];
  // dispatch renames the register that is committing
  logic renameHit;

  // busy registers ask the buffer for the producing entry
  assign queryTagA = tagOf[dispatch.rs1];
  assign queryTagB = tagOf[dispatch.rs2];

  // register file, or the buffer's answer when busy
  function automatic operand lookup(regIdx r, operand fromRob);
    operand o;
    o.ready = 1'b1;
    o.tag = '0;
    o.value = regFile[r];
    if (r == '0) begin
      o.value = '0;
    end else if (busy[r]) begin
      o = fromRob;
    end
    return o;
  endfunction

  always_comb begin
    srcA = lookup(dispatch.rs1, queryA);
    srcB = lookup(dispatch.rs2, queryB);
    // immediate replaces the second register
    if (dispatch.useImm) begin
      srcB.ready = 1'b1;
      srcB.tag = '0;
      srcB.value = dispatch.imm;
    end
  end

  assign renameHit = dispatchFire && (dispatch.rd == commit.rd);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busy <= '0;
      for (int i = 0; i < regCount; i++) begin
        regFile[i] <= '0;
      end
    end else begin
      // retire into the register file, register 0 stays zero
      if (commit.valid && commit.rd != '0) begin
        regFile[commit.rd] <= commit.value;
      end
      // free only if no younger producer took the register
      if (commit.valid && busy[commit.rd] && tagOf[commit.rd] == commitTag && !renameHit) begin
        busy[commit.rd] <= 1'b0;
      end
      if (dispatchFire && dispatch.rd != '0) begin
        busy[dispatch.rd] <= 1'b1;
      end
    end
  end

  // tag is only meaningful while busy
  always_ff @(posedge clk) begin
    if (dispatchFire && dispatch.rd != '0) begin
      tagOf[dispatch.rd] <= allocTag;
    end
  end

endmodule

`default_nettype wire

// File: logic/reorderBuffer.sv
// circular reorder buffer with in-order allocate and commit, bus capture and operand lookup
`timescale 1ns/10ps
`default_nettype none

module reorderBuffer import oooPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  logic     dispatchFire,
  input  regIdx    rd,
  output robTag    allocTag,
  output logic     robFull,
  input  robTag    queryTagA,
  input  robTag    queryTagB,
  output operand   queryA,
  output operand   queryB,
  input  cdbMsg    cdb,
  output commitMsg commit,
  output robTag    commitTag
);

  // per entry destination, result and completion
  regIdx entRd [robDepth];
  word entVal [robDepth];
  logic [robDepth-1:0] entDone;

  // oldest entry
  robTag head;
  // next free entry
  robTag tail;
  // occupied entries, 0 to 8
  logic [3:0] count;
  logic commitFire;

  assign allocTag = tail;
  assign robFull = (count == 4'(robDepth));

  // head retires once its result is in
  assign commitFire = (count != '0) && entDone[head];
  assign commitTag = head;

  always_comb begin
    commit.valid = commitFire;
    commit.rd = entRd[head];
    commit.value = entVal[head];
  end

  // operand answers for busy registers
  always_comb begin
    queryA.ready = entDone[queryTagA];
    queryA.tag = queryTagA;
    queryA.value = entVal[queryTagA];
    queryB.ready = entDone[queryTagB];
    queryB.tag = queryTagB;
    queryB.value = entVal[queryTagB];
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      entDone <= '0;
    end else begin
      // result arrives on the bus
      if (cdb.valid) begin
        entDone[cdb.tag] <= 1'b1;
      end
      // new entry starts incomplete
      if (dispatchFire) begin
        entDone[tail] <= 1'b0;
        tail <= tail + 3'd1;
      end
      if (commitFire) begin
        entDone[head] <= 1'b0;
        head <= head + 3'd1;
      end
      // net occupancy change
      count <= count + 4'(dispatchFire) - 4'(commitFire);
    end
  end

  // payload without reset
  always_ff @(posedge clk) begin
    if (dispatchFire) begin
      entRd[tail] <= rd;
    end
    if (cdb.valid) begin
      entVal[cdb.tag] <= cdb.value;
    end
  end

endmodule

`default_nettype wire

// File: sim/tbOooCore.sv
// testbench for the out-of-order back end with LFSR stimulus, reference model and commit checker
`timescale 1ns/10ps
`default_nettype none

module tbOooCore import oooPkg::*; ();

  localparam int streamCount = 150;
  localparam int chainCount = 100;
  localparam int burstChains = 4;
  localparam int burstLength = 15;
  localparam int zeroCount = 20;
  localparam int totalCount = streamCount + chainCount + burstChains * burstLength + zeroCount;
  // budget per instruction plus reset and drain
  localparam int cycleLimit = 20 * totalCount + 200;

  logic clk;
  logic arstN;
  logic dispatchValid;
  dispatchReq dispatch;
  logic dispatchReady;
  commitMsg commit;

  logic [31:0] lfsrState;
  // in-order model register file, entry 0 never written
  word modelReg [regCount];
  // expected retirements in program order
  commitMsg expectQ [$];
  string nameQ [$];
  string testName;
  commitMsg expected;
  string expectedName;
  int accepted;
  int committed;
  int checks;
  int errors;
  int cycleCount;

  oooCore UUT (
    .clk           (clk),
    .arstN         (arstN),
    .dispatchValid (dispatchValid),
    .dispatch      (dispatch),
    .dispatchReady (dispatchReady),
    .commit        (commit)
  );

  // starts high so time 0 gives no falling edge
  initial begin
    clk = 1'b1;
    forever #5 clk = ~clk;
  end

  // galois step, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] randBits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsrState[0]};
      lfsrState = lfsrNext(lfsrState);
    end
    return r;
  endfunction

  // expected ALU result
  function automatic word aluRef(aluOp op, word a, word b);
    case (op)
      opAdd: return a + b;
      opSub: return a - b;
      opAnd: return a & b;
      opOr: return a | b;
      opXor: return a ^ b;
      // only five bits of shift amount count
      opSll: return a << b[4:0];
      opSrl: return a >> b[4:0];
      opSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: return '0;
    endcase
  endfunction

  // run one accepted instruction on the model, queue its retirement
  function automatic void modelExecute(dispatchReq req);
    word a;
    word b;
    commitMsg exp;
    a = modelReg[req.rs1];
    b = req.useImm ? req.imm : modelReg[req.rs2];
    exp.valid = 1'b1;
    exp.rd = req.rd;
    exp.value = aluRef(req.op, a, b);
    // register 0 keeps reading zero
    if (req.rd != '0) begin
      modelReg[req.rd] = exp.value;
    end
    expectQ.push_back(exp);
    nameQ.push_back(testName);
  endfunction

  // called on a falling edge, valid stays high afterwards
  task automatic sendInstr(dispatchReq req);
    dispatchValid = 1'b1;
    dispatch = req;
    do begin
      @(posedge clk);
    end while (!dispatchReady);
    @(negedge clk);
  endtask

  task automatic idle(int n);
    dispatchValid = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  // acceptance, commit comparison and occupancy bound, all on pre-edge values
  always @(posedge clk) begin
    if (arstN) begin
      if (dispatchValid && dispatchReady) begin
        modelExecute(dispatch);
        accepted++;
      end
      if (commit.valid) begin
        assert (expectQ.size() != 0) else begin
          errors++;
          $display("a commit for rd %0d arrived with no instruction outstanding", commit.rd);
        end
        if (expectQ.size() != 0) begin
          expected = expectQ.pop_front();
          expectedName = nameQ.pop_front();
          checks++;
          committed++;
          assert (commit.rd == expected.rd) else begin
            errors++;
            $display("Error %s: rd expected %0d actual %0d", expectedName, expected.rd, commit.rd);
          end
          assert (commit.value == expected.value) else begin
            errors++;
            $display("Error %s: value expected %08h actual %08h",
                     expectedName, expected.value, commit.value);
          end
        end
      end
      // the ROB holds at most robDepth in flight
      assert (accepted - committed <= robDepth) else begin
        errors++;
        $display("%0d instructions in flight, more than the reorder buffer holds",
                 accepted - committed);
      end
    end
  end

  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    errors++;
    $display("timeout after %0d cycles, only %0d of %0d accepted instructions committed",
             cycleCount, committed, accepted);
    $display("checks %0d, errors %0d", checks, errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : stimulus
    dispatchReq req;
    regIdx prev1;
    regIdx prev2;
    arstN = 1'b0;
    dispatchValid = 1'b0;
    dispatch = '0;
    lfsrState = 32'h8b64_ba9a;
    accepted = 0;
    committed = 0;
    checks = 0;
    errors = 0;
    for (int i = 0; i < regCount; i++) begin
      modelReg[i] = '0;
    end

    testName = "reset";
    repeat (4) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    // idle core after reset
    repeat (3) begin
      @(negedge clk);
      checks++;
      assert (!commit.valid && dispatchReady) else begin
        errors++;
        $display("after reset commit.valid is %0b and dispatchReady is %0b",
                 commit.valid, dispatchReady);
      end
    end

    // random independent ops, big immediates give shift amounts above 31
    testName = "stream";
    for (int i = 0; i < streamCount; i++) begin
      req.op = aluOp'(randBits(3));
      req.rd = regIdx'(randBits(4));
      req.rs1 = regIdx'(randBits(4));
      req.rs2 = regIdx'(randBits(4));
      req.useImm = 1'(randBits(1));
      req.imm = randBits(32);
      sendInstr(req);
      if (randBits(2) == '0) idle(1);
    end

    // sources are the previous one or two destinations
    testName = "chain";
    prev1 = 4'd1;
    prev2 = 4'd2;
    for (int i = 0; i < chainCount; i++) begin
      req.op = aluOp'(randBits(3));
      req.rd = regIdx'(randBits(4));
      if (req.rd == '0) req.rd = 4'd7;
      req.rs1 = prev1;
      req.rs2 = prev2;
      // mostly register sources
      req.useImm = (randBits(2) == '0);
      req.imm = randBits(32);
      sendInstr(req);
      // gaps land consumers on a broadcast or on a done entry
      if (randBits(2) == '0) idle(1 + int'(randBits(1)));
      prev2 = prev1;
      prev1 = req.rd;
    end

    // long self-dependent chains, valid never drops
    testName = "burst";
    for (int c = 0; c < burstChains; c++) begin
      for (int i = 0; i < burstLength; i++) begin
        req.op = aluOp'(randBits(3));
        req.rd = regIdx'(c + 8);
        req.rs1 = regIdx'(c + 8);
        req.rs2 = regIdx'(c + 9);
        req.useImm = (i % 2 == 0);
        req.imm = randBits(32);
        sendInstr(req);
      end
    end

    // writes to r0 alternate with reads of r0
    testName = "zero";
    for (int i = 0; i < zeroCount; i++) begin
      req.op = aluOp'(randBits(3));
      req.imm = randBits(32);
      if (i % 2 == 0) begin
        req.rd = '0;
        req.rs1 = regIdx'(randBits(4));
        req.rs2 = regIdx'(randBits(4));
        req.useImm = 1'b1;
      end else begin
        req.rd = regIdx'(randBits(4));
        req.rs1 = '0;
        req.rs2 = '0;
        req.useImm = 1'(randBits(1));
      end
      sendInstr(req);
    end

    // drain, then make sure nothing extra retires
    idle(1);
    wait (committed == accepted);
    repeat (10) @(negedge clk);
    checks++;
    // empty ROB and station take dispatch again
    assert (dispatchReady && !commit.valid) else begin
      errors++;
      $display("drained core has dispatchReady %0b and commit.valid %0b",
               dispatchReady, commit.valid);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
logic/oooPkg.sv
logic/renameTable.sv
logic/reorderBuffer.sv
logic/aluStation.sv
logic/aluPipe.sv
logic/oooCore.sv
sim/tbOooCore.sv
